/* src/isaPkg.sv */
package isaPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;

    // primary opcode, instr[31:26], MIPS encodings
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_SLTI  = 6'd10,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14
    } opcodeT;

    // R-type funct field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } aluOpT;

    // one decoded instruction, roughly 57 bits
    typedef struct packed {
        aluOpT                   aluOp;
        logic                    useImm;
        logic                    we;
        logic [regAddrWidth-1:0] dest;
        logic [regAddrWidth-1:0] srcA;
        logic [regAddrWidth-1:0] srcB;
        logic [4:0]              shamt;
        logic [dataWidth-1:0]    imm;
    } decodedT;

endpackage

/* src/writebackIf.sv */
`timescale 1ns/1ps

// writeback stage results of both lanes
interface writebackIf
    import isaPkg::*;
();

    // enables already include the global enable and a non-zero destination
    logic                    en1;
    logic [regAddrWidth-1:0] dest1;
    logic [dataWidth-1:0]    data1;
    logic                    en2;
    logic [regAddrWidth-1:0] dest2;
    logic [dataWidth-1:0]    data2;

    modport source (
        output en1, dest1, data1,
        output en2, dest2, data2
    );

    modport sink (
        input en1, dest1, data1,
        input en2, dest2, data2
    );

endinterface

/* src/bundleFetch.sv */
`timescale 1ns/1ps

module bundleFetch
    import isaPkg::*;
#(
    parameter int pcWidth = 11
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 enable,
    input  logic [dataWidth-1:0] instr1,
    input  logic [dataWidth-1:0] instr2,
    output logic [pcWidth-1:0]   pc,
    output logic [dataWidth-1:0] idInstr1,
    output logic [dataWidth-1:0] idInstr2,
    output logic                 idValid
);

    // bundle counter, two instructions per accepted bundle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            idValid <= 1'b0;
        end else if (enable) begin
            pc      <= pc + pcWidth'(2);
            idValid <= 1'b1;
        end
    end

    // capture register feeding the decoders
    always_ff @(posedge clk) begin
        if (enable) begin
            idInstr1 <= instr1;
            idInstr2 <= instr2;
        end
    end

endmodule

/* src/laneDecoder.sv */
`timescale 1ns/1ps

module laneDecoder
    import isaPkg::*;
(
    input  logic [dataWidth-1:0] instr,
    input  logic                 valid,
    output decodedT              decoded
);

    opcodeT opcode;
    functT  funct;
    logic   known;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);

    always_comb begin
        known          = 1'b1;
        decoded.aluOp  = ALU_ADD;
        decoded.useImm = 1'b1;

        case (opcode)
            OP_RTYPE: begin
                decoded.useImm = 1'b0;
                case (funct)
                    FN_ADD:  decoded.aluOp = ALU_ADD;
                    FN_SUB:  decoded.aluOp = ALU_SUB;
                    FN_AND:  decoded.aluOp = ALU_AND;
                    FN_OR:   decoded.aluOp = ALU_OR;
                    FN_XOR:  decoded.aluOp = ALU_XOR;
                    FN_SLT:  decoded.aluOp = ALU_SLT;
                    FN_SLL:  decoded.aluOp = ALU_SLL;
                    FN_SRL:  decoded.aluOp = ALU_SRL;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: decoded.aluOp = ALU_ADD;
            OP_SLTI: decoded.aluOp = ALU_SLT;
            OP_ANDI: decoded.aluOp = ALU_AND;
            OP_ORI:  decoded.aluOp = ALU_OR;
            OP_XORI: decoded.aluOp = ALU_XOR;
            default: known = 1'b0;
        endcase

        // R-type writes rd from rs, rt; I-type writes rt from rs only
        decoded.srcA = instr[25:21];
        if (decoded.useImm) begin
            decoded.dest = instr[20:16];
            decoded.srcB = '0;
        end else begin
            decoded.dest = instr[15:11];
            decoded.srcB = instr[20:16];
        end

        decoded.shamt = instr[10:6];
        decoded.imm   = {{(dataWidth-16){instr[15]}}, instr[15:0]};

        // empty slot, unknown encoding or r0 as target writes nothing
        decoded.we = valid && known && (decoded.dest != '0);
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile
    import isaPkg::*;
(
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rdIdxA1,
    input  logic [regAddrWidth-1:0] rdIdxB1,
    input  logic [regAddrWidth-1:0] rdIdxA2,
    input  logic [regAddrWidth-1:0] rdIdxB2,
    output logic [dataWidth-1:0]    rdDataA1,
    output logic [dataWidth-1:0]    rdDataB1,
    output logic [dataWidth-1:0]    rdDataA2,
    output logic [dataWidth-1:0]    rdDataB2,
    writebackIf.sink                wb
);

    logic [dataWidth-1:0]    regs   [numRegs];
    logic [regAddrWidth-1:0] rdIdx  [4];
    logic [dataWidth-1:0]    rdData [4];

    // lane 2 is written last so it wins on a shared index
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.en1) begin
                regs[wb.dest1] <= wb.data1;
            end
            if (wb.en2) begin
                regs[wb.dest2] <= wb.data2;
            end
        end
    end

    assign rdIdx[0] = rdIdxA1;
    assign rdIdx[1] = rdIdxB1;
    assign rdIdx[2] = rdIdxA2;
    assign rdIdx[3] = rdIdxB2;

    // write-to-read bypass, same priority as the write
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdData[p] = regs[rdIdx[p]];
            if (wb.en1 && wb.dest1 == rdIdx[p]) begin
                rdData[p] = wb.data1;
            end
            if (wb.en2 && wb.dest2 == rdIdx[p]) begin
                rdData[p] = wb.data2;
            end
            if (rdIdx[p] == '0) begin
                rdData[p] = '0;
            end
        end
    end

    assign rdDataA1 = rdData[0];
    assign rdDataB1 = rdData[1];
    assign rdDataA2 = rdData[2];
    assign rdDataB2 = rdData[3];

endmodule

/* src/operandForward.sv */
`timescale 1ns/1ps

module operandForward
    import isaPkg::*;
(
    input  logic [regAddrWidth-1:0] srcA1,
    input  logic [regAddrWidth-1:0] srcB1,
    input  logic [regAddrWidth-1:0] srcA2,
    input  logic [regAddrWidth-1:0] srcB2,
    input  logic [dataWidth-1:0]    regA1,
    input  logic [dataWidth-1:0]    regB1,
    input  logic [dataWidth-1:0]    regA2,
    input  logic [dataWidth-1:0]    regB2,
    writebackIf.sink                wb,
    output logic [dataWidth-1:0]    opA1,
    output logic [dataWidth-1:0]    opB1,
    output logic [dataWidth-1:0]    opA2,
    output logic [dataWidth-1:0]    opB2
);

    logic [regAddrWidth-1:0] src     [4];
    logic [dataWidth-1:0]    regData [4];
    logic [dataWidth-1:0]    operand [4];

    assign src[0]     = srcA1;
    assign src[1]     = srcB1;
    assign src[2]     = srcA2;
    assign src[3]     = srcB2;
    assign regData[0] = regA1;
    assign regData[1] = regB1;
    assign regData[2] = regA2;
    assign regData[3] = regB2;

    // the bundle one ahead sits in writeback; lane 2 checked last
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            operand[k] = regData[k];
            if (wb.en1 && wb.dest1 == src[k]) begin
                operand[k] = wb.data1;
            end
            if (wb.en2 && wb.dest2 == src[k]) begin
                operand[k] = wb.data2;
            end
        end
    end

    assign opA1 = operand[0];
    assign opB1 = operand[1];
    assign opA2 = operand[2];
    assign opB2 = operand[3];

endmodule

/* src/laneAlu.sv */
`timescale 1ns/1ps

module laneAlu
    import isaPkg::*;
(
    input  aluOpT                aluOp,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] result
);

    logic lessThan;

    // signed compare for SLT and SLTI
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(dataWidth-1){1'b0}}, lessThan};
            // shifts take rt as the shifted value
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            default: result = '0;
        endcase
    end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage
    import isaPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 enable,
    input  decodedT              dec1,
    input  decodedT              dec2,
    input  logic [dataWidth-1:0] rd1A,
    input  logic [dataWidth-1:0] rd1B,
    input  logic [dataWidth-1:0] rd2A,
    input  logic [dataWidth-1:0] rd2B,
    writebackIf.source           wb,
    writebackIf.sink             wbFwd
);

    decodedT                 exDec1, exDec2;
    logic                    exWe1, exWe2;
    logic [dataWidth-1:0]    exA1, exB1, exA2, exB2;
    logic [dataWidth-1:0]    opA1, opB1, opA2, opB2;
    logic [dataWidth-1:0]    aluB1, aluB2;
    logic [dataWidth-1:0]    result1, result2;
    logic                    wbWe1, wbWe2;
    logic [regAddrWidth-1:0] wbDest1, wbDest2;
    logic [dataWidth-1:0]    wbResult1, wbResult2;

    // stage valid flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exWe1 <= 1'b0;
            exWe2 <= 1'b0;
            wbWe1 <= 1'b0;
            wbWe2 <= 1'b0;
        end else if (enable) begin
            exWe1 <= dec1.we;
            exWe2 <= dec2.we;
            wbWe1 <= exWe1;
            wbWe2 <= exWe2;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            exDec1    <= dec1;
            exDec2    <= dec2;
            exA1      <= rd1A;
            exB1      <= rd1B;
            exA2      <= rd2A;
            exB2      <= rd2B;
            wbDest1   <= exDec1.dest;
            wbDest2   <= exDec2.dest;
            wbResult1 <= result1;
            wbResult2 <= result2;
        end
    end

    operandForward fwd (
        .srcA1(exDec1.srcA), .srcB1(exDec1.srcB), .srcA2(exDec2.srcA), .srcB2(exDec2.srcB),
        .regA1(exA1), .regB1(exB1), .regA2(exA2), .regB2(exB2), .wb(wbFwd),
        .opA1(opA1), .opB1(opB1), .opA2(opA2), .opB2(opB2)
    );

    assign aluB1 = exDec1.useImm ? exDec1.imm : opB1;
    assign aluB2 = exDec2.useImm ? exDec2.imm : opB2;

    laneAlu alu1 (.aluOp(exDec1.aluOp), .a(opA1), .b(aluB1), .shamt(exDec1.shamt), .result(result1));
    laneAlu alu2 (.aluOp(exDec2.aluOp), .a(opA2), .b(aluB2), .shamt(exDec2.shamt), .result(result2));

    // a frozen pipeline commits nothing
    assign wb.en1   = wbWe1 && enable;
    assign wb.dest1 = wbDest1;
    assign wb.data1 = wbResult1;
    assign wb.en2   = wbWe2 && enable;
    assign wb.dest2 = wbDest2;
    assign wb.data2 = wbResult2;

endmodule

/* src/dualIssueCore.sv */
`timescale 1ns/1ps

module dualIssueCore
    import isaPkg::*;
#(
    parameter int pcWidth = 11
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    enable,
    input  logic [dataWidth-1:0]    instr1,
    input  logic [dataWidth-1:0]    instr2,
    output logic [pcWidth-1:0]      pc,
    output logic                    wbEn1,
    output logic [regAddrWidth-1:0] wbReg1,
    output logic [dataWidth-1:0]    wbData1,
    output logic                    wbEn2,
    output logic [regAddrWidth-1:0] wbReg2,
    output logic [dataWidth-1:0]    wbData2
);

    logic [dataWidth-1:0] idInstr1, idInstr2;
    logic                 idValid;
    decodedT              decoded1, decoded2;
    logic [dataWidth-1:0] rdA1, rdB1, rdA2, rdB2;

    writebackIf wbBus ();

    bundleFetch #(.pcWidth(pcWidth)) fetch (
        .clk(clk), .arstN(arstN), .enable(enable), .instr1(instr1), .instr2(instr2),
        .pc(pc), .idInstr1(idInstr1), .idInstr2(idInstr2), .idValid(idValid)
    );

    laneDecoder decode1 (.instr(idInstr1), .valid(idValid), .decoded(decoded1));
    laneDecoder decode2 (.instr(idInstr2), .valid(idValid), .decoded(decoded2));

    regFile rf (
        .clk(clk), .arstN(arstN),
        .rdIdxA1(decoded1.srcA), .rdIdxB1(decoded1.srcB),
        .rdIdxA2(decoded2.srcA), .rdIdxB2(decoded2.srcB),
        .rdDataA1(rdA1), .rdDataB1(rdB1), .rdDataA2(rdA2), .rdDataB2(rdB2),
        .wb(wbBus.sink)
    );

    executeStage execute (
        .clk(clk), .arstN(arstN), .enable(enable), .dec1(decoded1), .dec2(decoded2),
        .rd1A(rdA1), .rd1B(rdB1), .rd2A(rdA2), .rd2B(rdB2),
        .wb(wbBus.source), .wbFwd(wbBus.sink)
    );

    assign wbEn1   = wbBus.en1;
    assign wbReg1  = wbBus.dest1;
    assign wbData1 = wbBus.data1;
    assign wbEn2   = wbBus.en2;
    assign wbReg2  = wbBus.dest2;
    assign wbData2 = wbBus.data2;

endmodule

/* tb/dualIssueCore_assert.sv */
`timescale 1ns/1ps

module dualIssueCore_assert
    import isaPkg::*;
#(
    parameter int pcWidth = 11
) (
    input logic                    clk,
    input logic                    arstN,
    input logic                    enable,
    input logic [pcWidth-1:0]      pc,
    input logic                    wbEn1,
    input logic                    wbEn2,
    input logic [regAddrWidth-1:0] wbReg1,
    input logic [regAddrWidth-1:0] wbReg2
);

    // r0 is never a writeback target
    noWriteR0: assert property (@(posedge clk)
        !(wbEn1 && wbReg1 == '0) && !(wbEn2 && wbReg2 == '0))
        else $error("writeback enabled toward register 0");

    quietWhenIdle: assert property (@(posedge clk) (!arstN || !enable) |-> !wbEn1 && !wbEn2)
        else $error("writeback enabled during reset or while disabled");

    // two instructions per enabled edge, hold otherwise
    pcAdvance: assert property (@(posedge clk) arstN && $past(arstN) |->
        pc == ($past(enable) ? $past(pc) + pcWidth'(2) : $past(pc)))
        else $error("bundle counter did not follow enable");

endmodule

bind dualIssueCore dualIssueCore_assert #(.pcWidth(pcWidth)) props (
    .clk(clk), .arstN(arstN), .enable(enable), .pc(pc),
    .wbEn1(wbEn1), .wbEn2(wbEn2), .wbReg1(wbReg1), .wbReg2(wbReg2)
);

/* tb/dualIssueCore_tb.sv */
`timescale 1ns/1ps

module dualIssueCore_tb
    import isaPkg::*;
();

    localparam int pcWidth   = 11;
    localparam int numRandom = 200;
    // directed cycles plus random bundles with up to three idle cycles each
    localparam int maxCycles = 200 + numRandom * 4;
    localparam int timeoutNs = maxCycles * 10;

    localparam logic [dataWidth-1:0] nop = '0;
    localparam functT  fnList [8] = '{FN_ADD, FN_SUB, FN_AND, FN_OR,
                                      FN_XOR, FN_SLT, FN_SLL, FN_SRL};
    localparam opcodeT opList [5] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};

    // expected writeback of one bundle
    typedef struct packed {
        logic                    we1;
        logic [regAddrWidth-1:0] reg1;
        logic [dataWidth-1:0]    data1;
        logic                    we2;
        logic [regAddrWidth-1:0] reg2;
        logic [dataWidth-1:0]    data2;
    } expectT;

    logic                    clk, arstN, enable;
    logic [dataWidth-1:0]    instr1, instr2;
    logic [pcWidth-1:0]      pc;
    logic                    wbEn1, wbEn2;
    logic [regAddrWidth-1:0] wbReg1, wbReg2;
    logic [dataWidth-1:0]    wbData1, wbData2;

    // reference register file and the expected contents of each pipeline stage
    logic [dataWidth-1:0] modelRegs [numRegs];
    expectT               pendingExp, idExp, exExp, wbExp;
    logic [pcWidth-1:0]   expPc;
    logic                 lastEn;
    int                   checkCount;

    dualIssueCore #(.pcWidth(pcWidth)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(timeoutNs);
        $display("Testbench failed");
        $fatal(1, "watchdog expired before all tests finished");
    end

    function automatic logic [dataWidth-1:0] rType(functT fn, int rd, int rs, int rt, int sh = 0);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [dataWidth-1:0] iType(opcodeT op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [dataWidth-1:0] randomInstr();
        if ($urandom_range(1) == 1) begin
            return rType(fnList[3'($urandom_range(7))], $urandom_range(7), $urandom_range(7),
                         $urandom_range(7), $urandom_range(31));
        end
        return iType(opList[3'($urandom_range(4))], $urandom_range(7), $urandom_range(7),
                     $urandom_range(65535));
    endfunction

    // one instruction against the register state before its bundle
    function automatic void predict(input logic [dataWidth-1:0] code, output logic we,
                                    output logic [regAddrWidth-1:0] dest,
                                    output logic [dataWidth-1:0] val);
        logic [dataWidth-1:0] rs, rt, imm;
        rs   = modelRegs[code[25:21]];
        rt   = modelRegs[code[20:16]];
        imm  = {{16{code[15]}}, code[15:0]};
        we   = 1'b1;
        val  = '0;
        dest = (code[31:26] == OP_RTYPE) ? code[15:11] : code[20:16];
        case (code[31:26])
            OP_RTYPE: case (code[5:0])
                FN_ADD:  val = rs + rt;
                FN_SUB:  val = rs - rt;
                FN_AND:  val = rs & rt;
                FN_OR:   val = rs | rt;
                FN_XOR:  val = rs ^ rt;
                FN_SLT:  val = dataWidth'($signed(rs) < $signed(rt));
                FN_SLL:  val = rt << code[10:6];
                FN_SRL:  val = rt >> code[10:6];
                default: we = 1'b0;
            endcase
            OP_ADDI: val = rs + imm;
            OP_SLTI: val = dataWidth'($signed(rs) < $signed(imm));
            OP_ANDI: val = rs & imm;
            OP_ORI:  val = rs | imm;
            OP_XORI: val = rs ^ imm;
            default: we = 1'b0;
        endcase
        if (dest == '0) we = 1'b0;
    endfunction

    function automatic expectT applyBundle(input logic [dataWidth-1:0] i1, i2);
        expectT e;
        predict(i1, e.we1, e.reg1, e.data1);
        predict(i2, e.we2, e.reg2, e.data2);
        // both lanes read first, lane 2 commits last
        if (e.we1) modelRegs[e.reg1] = e.data1;
        if (e.we2) modelRegs[e.reg2] = e.data2;
        return e;
    endfunction

    task automatic reportMismatch(input string what, input logic [dataWidth-1:0] got, exp);
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        $display("Testbench failed");
        $fatal(1, "value mismatch on %s", what);
    endtask

    task automatic checkData(input string what, input logic [dataWidth-1:0] got, exp);
        checkCount++;
        if (got !== exp) reportMismatch(what, got, exp);
    endtask

    task automatic checkReg(input string what, input logic [regAddrWidth-1:0] got, exp);
        checkCount++;
        if (got !== exp) reportMismatch(what, dataWidth'(got), dataWidth'(exp));
    endtask

    task automatic checkPc(input string what, input logic [pcWidth-1:0] got, exp);
        checkCount++;
        if (got !== exp) reportMismatch(what, dataWidth'(got), dataWidth'(exp));
    endtask

    task automatic checkFlag(input string what, input logic got, exp);
        checkCount++;
        if (got !== exp) reportMismatch(what, dataWidth'(got), dataWidth'(exp));
    endtask

    // advance the model past the edge, drive the next bundle, check at the falling edge
    task automatic stepCycle(input logic [dataWidth-1:0] i1, i2, input logic en);
        @(posedge clk);
        if (lastEn) begin
            wbExp = exExp;
            exExp = idExp;
            idExp = pendingExp;
            expPc = expPc + pcWidth'(2);
        end
        instr1 <= i1;
        instr2 <= i2;
        enable <= en;
        lastEn = en;
        if (en) pendingExp = applyBundle(i1, i2);
        @(negedge clk);
        checkPc("pc", pc, expPc);
        checkFlag("wbEn1", wbEn1, en && wbExp.we1);
        checkFlag("wbEn2", wbEn2, en && wbExp.we2);
        if (en && wbExp.we1) begin
            checkReg("wbReg1", wbReg1, wbExp.reg1);
            checkData("wbData1", wbData1, wbExp.data1);
        end
        if (en && wbExp.we2) begin
            checkReg("wbReg2", wbReg2, wbExp.reg2);
            checkData("wbData2", wbData2, wbExp.data2);
        end
    endtask

    task automatic flushPipe();
        repeat (3) stepCycle(nop, nop, 1'b1);
    endtask

    task automatic afterReset();
        @(negedge clk);
        checkPc("pc after reset", pc, '0);
        checkFlag("wbEn1 after reset", wbEn1, 1'b0);
        checkFlag("wbEn2 after reset", wbEn2, 1'b0);
        // unknown opcode in lane 1, unknown funct in lane 2
        repeat (4) stepCycle({6'h3f, 26'h1234567}, {OP_RTYPE, 15'h4a5, 5'd0, 6'h3f}, 1'b1);
        flushPipe();
    endtask

    task automatic aluOps();
        stepCycle(iType(OP_ADDI, 1, 0, -5), iType(OP_ADDI, 2, 0, 300), 1'b1);
        stepCycle(iType(OP_ADDI, 3, 0, -32768), iType(OP_ADDI, 4, 0, 32767), 1'b1);
        for (int k = 0; k < 8; k++) begin
            stepCycle(rType(fnList[3'(k)], 8 + k, 1, 2, 3),
                      rType(fnList[3'(k)], 16 + k, 4, 3, 29), 1'b1);
        end
        for (int k = 0; k < 5; k++) begin
            stepCycle(iType(opList[3'(k)], 24 + k, 1, -20),
                      iType(opList[3'(k)], 29 + (k % 3), 4, 16'h8765), 1'b1);
        end
        flushPipe();
    endtask

    task automatic forwarding();
        // back to back, each lane takes both lanes of the bundle ahead
        stepCycle(iType(OP_ADDI, 5, 0, 11), iType(OP_ADDI, 6, 0, -7), 1'b1);
        stepCycle(rType(FN_ADD, 7, 5, 6), rType(FN_SUB, 8, 6, 5), 1'b1);
        stepCycle(rType(FN_XOR, 9, 8, 7), rType(FN_OR, 10, 7, 8), 1'b1);
        // two apart goes through the register file bypass
        stepCycle(iType(OP_ADDI, 11, 0, 100), iType(OP_ADDI, 12, 0, -100), 1'b1);
        stepCycle(nop, nop, 1'b1);
        stepCycle(rType(FN_SUB, 13, 11, 12), rType(FN_SLT, 14, 12, 11), 1'b1);
        stepCycle(nop, nop, 1'b1);
        stepCycle(nop, nop, 1'b1);
        stepCycle(rType(FN_ADD, 15, 13, 14), rType(FN_SRL, 16, 0, 12, 4), 1'b1);
        flushPipe();
    endtask

    task automatic sameBundle();
        stepCycle(iType(OP_ADDI, 3, 0, 40), iType(OP_ADDI, 4, 0, 2), 1'b1);
        // lane 2 reads r3 before lane 1 of the same bundle rewrites it
        stepCycle(iType(OP_ADDI, 3, 3, 1), rType(FN_ADD, 5, 3, 4), 1'b1);
        // both lanes target r6
        stepCycle(iType(OP_ADDI, 6, 0, 111), iType(OP_ADDI, 6, 0, 222), 1'b1);
        stepCycle(rType(FN_OR, 7, 6, 0), nop, 1'b1);
        stepCycle(nop, nop, 1'b1);
        stepCycle(nop, rType(FN_ADD, 8, 6, 6), 1'b1);
        stepCycle(iType(OP_ADDI, 0, 3, 9), rType(FN_ADD, 0, 3, 4), 1'b1);
        flushPipe();
    endtask

    task automatic enableHold();
        stepCycle(iType(OP_ADDI, 9, 0, 55), iType(OP_XORI, 10, 0, 16'h0f0f), 1'b1);
        stepCycle(rType(FN_ADD, 11, 9, 10), nop, 1'b1);
        stepCycle(nop, rType(FN_SUB, 12, 11, 9), 1'b1);
        // garbage on the ports while frozen must not be taken
        repeat (5) stepCycle($urandom, $urandom, 1'b0);
        stepCycle(rType(FN_AND, 13, 12, 11), nop, 1'b1);
        repeat (3) stepCycle($urandom, $urandom, 1'b0);
        flushPipe();
    endtask

    task automatic randomBundles();
        for (int n = 0; n < numRandom; n++) begin
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(3, 1)) stepCycle($urandom, $urandom, 1'b0);
            end
            stepCycle(randomInstr(), randomInstr(), 1'b1);
        end
        flushPipe();
    endtask

    initial begin
        void'($urandom(32'h0631b6ad));
        arstN      = 1'b1;
        enable     = 1'b0;
        instr1     = '0;
        instr2     = '0;
        modelRegs  = '{default: '0};
        pendingExp = '0;
        idExp      = '0;
        exExp      = '0;
        wbExp      = '0;
        expPc      = '0;
        // the first edge after reset release already takes the nop bundle
        lastEn     = 1'b1;
        checkCount = 0;
        @(posedge clk);
        arstN  <= 1'b0;
        // reset has to keep the pipeline empty even with enable high
        enable <= 1'b1;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        afterReset();
        aluOps();
        forwarding();
        sameBundle();
        enableHold();
        randomBundles();

        if (checkCount > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "no checks were executed");
        end
    end

endmodule

/* flist.f */
src/isaPkg.sv
src/writebackIf.sv
src/bundleFetch.sv
src/laneDecoder.sv
src/regFile.sv
src/operandForward.sv
src/laneAlu.sv
src/executeStage.sv
src/dualIssueCore.sv
tb/dualIssueCore_assert.sv
tb/dualIssueCore_tb.sv

/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := dualIssueCore_tb
FLIST      := flist.f
OBJDIR     := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
